// File: logic/div_sqrt_pkg.sv
// Shared widths, encodings and payload types for the divide/sqrt
// normalize-and-round back end. Every design file refers to these
// through scoped names.

package div_sqrt_pkg;

  //////////////////////////////////////////////////////////////////////
  // Format field widths
  //////////////////////////////////////////////////////////////////////
  localparam int c_mant_fp32 = 23;
  localparam int c_exp_fp32  = 8;
  localparam int c_mant_fp16 = 10;
  localparam int c_exp_fp16  = 5;

  localparam int c_rnd_w     = 4;                          // Extra bits below FP32 LSB
  localparam int c_mant_in_w = 1 + c_mant_fp32 + c_rnd_w;  // Hidden + fraction + rounding
  localparam int c_exp_in_w  = c_exp_fp32 + 2;             // Room for sign and overflow
  localparam int c_fp16_lsb  = c_mant_fp32 - c_mant_fp16;  // FP16 last place inside FP32 frac

  // Quiet NaN, top fraction bit only
  localparam logic [c_mant_fp32-1:0] c_qnan_mant = {1'b1, {(c_mant_fp32-1){1'b0}}};
  localparam logic [15:0]            c_box16     = 16'hffff;  // NaN box for FP16

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////
  typedef enum logic {
    fmt_fp32 = 1'b0,
    fmt_fp16 = 1'b1
  } fmt_e;

  // Unlisted codes behave as rtz
  typedef enum logic [2:0] {
    rm_rne = 3'd0,  // Nearest, ties to even
    rm_rtz = 3'd1,  // Toward zero
    rm_rdn = 3'd2,  // Toward minus infinity
    rm_rup = 3'd3   // Toward plus infinity
  } rm_e;

  //////////////////////////////////////////////////////////////////////
  // Payload structs
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic inf_a;
    logic inf_b;
    logic zero_a;
    logic zero_b;
    logic nan_a;
    logic nan_b;
    logic snan;     // Either NaN operand is signalling
  } op_class_t;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed {
    logic [c_mant_in_w-1:0]        mant;     // Unnormalized quotient or root
    logic signed [c_exp_in_w-1:0]  exp;      // Biased for the target format
    logic                          sign;
    logic                          sqrt_op;  // 1 sqrt, 0 divide
    op_class_t                     cls;
    rm_e                           rm;
    fmt_e                          fmt;
  } norm_in_t;

  typedef struct packed {
    logic [31:0] result;
    fflags_t     flags;
  } norm_out_t;

  // Fixed result for special operands
  typedef struct packed {
    logic hit;
    logic sign;
    logic exp_ones;   // Exponent all ones, else zero
    logic quiet_nan;  // Fraction is canonical qNaN, else zero
    logic nv;
    logic dz;
    logic of;
  } special_t;

  typedef struct packed {
    logic [c_mant_fp32:0]    mant_norm;   // Hidden bit plus FP32 fraction
    logic [c_rnd_w-1:0]      mant_extra;  // Guard, round, sticky sources
    logic [c_exp_fp32-1:0]   exp;
    logic                    of;
    logic                    uf;
  } shifted_t;

endpackage

// File: logic/fp_pipe_reg.sv
// Single pipeline stage with a valid strobe, used for any payload type.
// Valid moves every cycle; the payload only loads on a valid input.

`timescale 1ns/1ps

module fp_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     valid_in,
  input  payload_t d,
  output logic     valid_out,
  output payload_t q
);

  // Strobe register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_out <= 1'b0;
    end
    else
    begin
      valid_out <= valid_in;  // One cycle per stage
    end
  end

  // Payload holds its value across idle cycles
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      q <= '0;
    end
    else if (valid_in)
    begin
      q <= d;
    end
  end

  // Downstream stages trust the strobe, so X here would spread
  a_valid_known : assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(valid_out))
    else $error("pipe stage valid_out is unknown");

endmodule

// File: logic/norm_special.sv
// Special-operand resolution for divide and square root.
// Classifies NaN, infinity, zero, divide by zero and negative root
// into a fixed result descriptor; hit stays low for regular operands.

`timescale 1ns/1ps

module norm_special (
  input  div_sqrt_pkg::norm_in_t in_data,
  output div_sqrt_pkg::special_t special
);

  logic div_op;
  logic sqrt_op;

  assign sqrt_op = in_data.sqrt_op;
  assign div_op  = ~in_data.sqrt_op;

  //////////////////////////////////////////////////////////////////////
  // Result builders
  //////////////////////////////////////////////////////////////////////
  function automatic div_sqrt_pkg::special_t nan_res(input logic nv, input logic dz);
    div_sqrt_pkg::special_t r;
    r           = '0;
    r.hit       = 1'b1;
    r.exp_ones  = 1'b1;
    r.quiet_nan = 1'b1;  // Canonical NaN, sign 0
    r.nv        = nv;
    r.dz        = dz;
    return r;
  endfunction

  function automatic div_sqrt_pkg::special_t inf_res(input logic sign, input logic of,
                                                      input logic dz);
    div_sqrt_pkg::special_t r;
    r          = '0;
    r.hit      = 1'b1;
    r.sign     = sign;
    r.exp_ones = 1'b1;
    r.of       = of;
    r.dz       = dz;
    return r;
  endfunction

  function automatic div_sqrt_pkg::special_t zero_res(input logic sign);
    div_sqrt_pkg::special_t r;
    r      = '0;
    r.hit  = 1'b1;
    r.sign = sign;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Priority chain, first match wins
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    special = '0;                                        // No special case
    if (in_data.cls.nan_a || in_data.cls.nan_b)
      special = nan_res(in_data.cls.snan, 1'b0);         // NaN in, NV only if signalling
    else if (in_data.cls.inf_a)
    begin
      if (div_op && in_data.cls.inf_b)
        special = nan_res(1'b1, 1'b0);                   // inf / inf
      else if (sqrt_op && in_data.sign)
        special = nan_res(1'b1, 1'b0);                   // sqrt(-inf)
      else
        special = inf_res(in_data.sign, 1'b1, 1'b0);     // Inf passes through
    end
    else if (div_op && in_data.cls.inf_b)
      special = zero_res(in_data.sign);                  // finite / inf
    else if (in_data.cls.zero_a)
    begin
      if (div_op && in_data.cls.zero_b)
        special = nan_res(1'b1, 1'b1);                   // 0 / 0
      else
        special = zero_res(in_data.sign);                // Keeps sign, sqrt(-0) too
    end
    else if (div_op && in_data.cls.zero_b)
      special = inf_res(in_data.sign, 1'b0, 1'b1);       // x / 0
    else if (sqrt_op && in_data.sign)
      special = nan_res(1'b1, 1'b0);                     // sqrt of negative
  end

  // Signalling marker only comes with a NaN operand
  always_comb
  begin : chk_snan_has_nan
    assert (!in_data.cls.snan || in_data.cls.nan_a || in_data.cls.nan_b)
      else $error("snan set without a NaN operand");
  end

endmodule

// File: logic/norm_shift.sv
// Normalization for regular operands. Removes a leading 0.1 pattern,
// right-shifts into subnormal range for small exponents with the lost
// bits folded into sticky, and flags exponent overflow per format.

`timescale 1ns/1ps

module norm_shift (
  input  div_sqrt_pkg::norm_in_t in_data,
  output div_sqrt_pkg::shifted_t shifted
);

  localparam int c_mw   = div_sqrt_pkg::c_mant_fp32 + 1;  // Hidden plus fraction
  localparam int c_rw   = div_sqrt_pkg::c_rnd_w;
  localparam int c_inw  = div_sqrt_pkg::c_mant_in_w;
  localparam int c_ew   = div_sqrt_pkg::c_exp_in_w + 1;   // One more for the decrement
  localparam int c_sh_w = c_inw + c_mw;                   // Room for a full flush

  logic signed [c_ew-1:0] exp_ext;
  logic signed [c_ew-1:0] exp_adj;    // Exponent after 0.1 fixup
  logic signed [c_ew-1:0] exp_max;    // All-ones exponent of the format
  logic [c_inw-1:0]       mant_adj;
  logic [c_ew-1:0]        rs_amt;     // Right shift for subnormals
  logic [c_ew-1:0]        mant_w;
  logic [c_sh_w-1:0]      sh_vec;
  logic                   sh_lost;

  assign exp_ext = {in_data.exp[div_sqrt_pkg::c_exp_in_w-1], in_data.exp};

  // 1.xxx keeps exponent, 0.1xx moves up one place
  assign mant_adj = in_data.mant[c_inw-1] ? in_data.mant : {in_data.mant[c_inw-2:0], 1'b0};
  assign exp_adj  = in_data.mant[c_inw-1] ? exp_ext : exp_ext - 11'sd1;

  //////////////////////////////////////////////////////////////////////
  // Format limits
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (in_data.fmt == div_sqrt_pkg::fmt_fp16)
    begin
      exp_max = (c_ew)'((1 << div_sqrt_pkg::c_exp_fp16) - 1);  // 31
      mant_w  = (c_ew)'(div_sqrt_pkg::c_mant_fp16);
    end
    else
    begin
      exp_max = (c_ew)'((1 << div_sqrt_pkg::c_exp_fp32) - 1);  // 255
      mant_w  = (c_ew)'(div_sqrt_pkg::c_mant_fp32);
    end
  end

  // Exponent 0 still needs one place, the subnormal has no hidden bit
  assign rs_amt  = (c_ew)'(1) - exp_adj;
  assign sh_vec  = {mant_adj, {c_mw{1'b0}}} >> rs_amt;
  assign sh_lost = |sh_vec[c_mw-1:0];              // Below the extra bits

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    shifted = '0;
    if (exp_adj >= exp_max)
    begin
      shifted.of  = 1'b1;                          // Infinity, zero fraction
      shifted.exp = exp_max[div_sqrt_pkg::c_exp_fp32-1:0];
    end
    else if (exp_adj <= 0)
    begin
      shifted.uf = 1'b1;                           // Exponent field stays 0
      if (rs_amt <= mant_w)
      begin
        shifted.mant_norm  = sh_vec[c_sh_w-1 -: c_mw];
        shifted.mant_extra = {sh_vec[c_sh_w-c_mw-1 -: c_rw-1], sh_vec[c_mw] | sh_lost};
      end
    end
    else
    begin
      shifted.mant_norm  = mant_adj[c_inw-1 -: c_mw];  // Plain normal
      shifted.mant_extra = mant_adj[c_rw-1:0];
      shifted.exp        = exp_adj[div_sqrt_pkg::c_exp_fp32-1:0];
    end
  end

endmodule

// File: logic/norm_round.sv
// Rounding and result assembly. Rounds the normalized mantissa at the
// last place of the selected format, renormalizes on carry, lets a
// special case override, NaN-boxes FP16 and builds the flags.

`timescale 1ns/1ps

module norm_round (
  input  div_sqrt_pkg::special_t  special,
  input  div_sqrt_pkg::shifted_t  shifted,
  input  logic                    sign,
  input  div_sqrt_pkg::rm_e       rm,
  input  div_sqrt_pkg::fmt_e      fmt,
  output div_sqrt_pkg::norm_out_t out_data
);

  localparam int c_mw   = div_sqrt_pkg::c_mant_fp32 + 1;
  localparam int c_lsb  = div_sqrt_pkg::c_fp16_lsb;     // FP16 last place
  localparam int c_ew   = div_sqrt_pkg::c_exp_fp32;
  localparam int c_fw   = div_sqrt_pkg::c_mant_fp32;

  logic                 is_fp16;
  logic                 guard;
  logic                 rnd;
  logic                 sticky;
  logic                 lsb;
  logic                 inexact;
  logic                 round_up;
  logic [c_mw-1:0]      mant_upper;   // Bits kept by the format
  logic [c_mw-1:0]      mant_inc;     // One unit in the last place
  logic [c_mw:0]        mant_sum;
  logic                 carry;
  logic [c_mw-1:0]      mant_rnd;
  logic [c_ew-1:0]      exp_rnd;
  logic                 exp_full;
  logic                 sign_res;
  logic [c_ew-1:0]      exp_res;
  logic [c_fw-1:0]      frac_res;

  assign is_fp16 = (fmt == div_sqrt_pkg::fmt_fp16);

  //////////////////////////////////////////////////////////////////////
  // Guard, round and sticky at the format's last place
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (is_fp16)
    begin
      guard      = shifted.mant_norm[c_lsb-1];
      rnd        = shifted.mant_norm[c_lsb-2];
      sticky     = (|shifted.mant_norm[c_lsb-3:0]) | (|shifted.mant_extra);
      lsb        = shifted.mant_norm[c_lsb];
      mant_upper = {shifted.mant_norm[c_mw-1:c_lsb], {c_lsb{1'b0}}};
      mant_inc   = {{(c_mw-c_lsb-1){1'b0}}, 1'b1, {c_lsb{1'b0}}};
    end
    else
    begin
      guard      = shifted.mant_extra[3];
      rnd        = shifted.mant_extra[2];
      sticky     = |shifted.mant_extra[1:0];
      lsb        = shifted.mant_norm[0];
      mant_upper = shifted.mant_norm;
      mant_inc   = {{(c_mw-1){1'b0}}, 1'b1};
    end
  end

  assign inexact = guard | rnd | sticky;

  always_comb
  begin
    case (rm)
      div_sqrt_pkg::rm_rne: round_up = guard & (rnd | sticky | lsb);
      div_sqrt_pkg::rm_rup: round_up = inexact & ~sign;
      div_sqrt_pkg::rm_rdn: round_up = inexact & sign;
      default:              round_up = 1'b0;       // rtz and unused codes
    endcase
  end

  // Carry out means 10.000, shift back and bump exponent
  assign mant_sum = {1'b0, mant_upper} + (round_up ? mant_inc : '0);
  assign carry    = mant_sum[c_mw];
  assign mant_rnd = carry ? mant_sum[c_mw:1] : mant_sum[c_mw-1:0];

  // A subnormal that rounds up into the hidden bit becomes exponent 1
  assign exp_rnd  = (shifted.exp == '0) ? {{(c_ew-1){1'b0}}, mant_rnd[c_mw-1]}
                                        : shifted.exp + {{(c_ew-1){1'b0}}, carry};
  assign exp_full = is_fp16 ? (exp_rnd[div_sqrt_pkg::c_exp_fp16-1:0] == '1)
                            : (exp_rnd == '1);

  //////////////////////////////////////////////////////////////////////
  // Special override, packing and flags
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    out_data.flags = '0;
    if (special.hit)
    begin
      sign_res          = special.sign;
      exp_res           = special.exp_ones ? '1 : '0;
      frac_res          = special.quiet_nan ? div_sqrt_pkg::c_qnan_mant : '0;
      out_data.flags.nv = special.nv;
      out_data.flags.dz = special.dz;
      out_data.flags.of = special.of;
    end
    else
    begin
      sign_res          = sign;
      exp_res           = exp_rnd;
      frac_res          = mant_rnd[c_fw-1:0];
      out_data.flags.of = shifted.of | exp_full;     // Includes rounding overflow
      out_data.flags.uf = shifted.uf;
      out_data.flags.nx = inexact;
    end
    if (is_fp16)
      out_data.result = {div_sqrt_pkg::c_box16, sign_res,
                         exp_res[div_sqrt_pkg::c_exp_fp16-1:0],
                         frac_res[c_fw-1 -: div_sqrt_pkg::c_mant_fp16]};
    else
      out_data.result = {sign_res, exp_res, frac_res};
  end

  always_comb
  begin : chk_of_uf
    assert (!(out_data.flags.of && out_data.flags.uf))
      else $error("of and uf raised together");
  end

endmodule

// File: logic/norm_round_unit.sv
// Top of the normalize-and-round unit. Input register, combinational
// special/shift/round core, output register. Fixed latency of two
// cycles, a new item may enter every cycle, no back-pressure.

`timescale 1ns/1ps

module norm_round_unit (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  input  div_sqrt_pkg::norm_in_t  in_data,
  output logic                    out_valid,
  output div_sqrt_pkg::norm_out_t out_data
);

  div_sqrt_pkg::norm_in_t  in_q;      // Registered operand
  logic                    in_q_valid;
  div_sqrt_pkg::special_t  special;
  div_sqrt_pkg::shifted_t  shifted;
  div_sqrt_pkg::norm_out_t out_d;     // Core result before output stage

  //////////////////////////////////////////////////////////////////////
  // Stage 1, capture
  //////////////////////////////////////////////////////////////////////
  fp_pipe_reg #(
    .payload_t (div_sqrt_pkg::norm_in_t)
  ) u_in_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_in  (in_valid),
    .d         (in_data),
    .valid_out (in_q_valid),
    .q         (in_q)
  );

  // Special and shift paths run side by side
  norm_special u_special (
    .in_data (in_q),
    .special (special)
  );

  norm_shift u_shift (
    .in_data (in_q),
    .shifted (shifted)
  );

  norm_round u_round (
    .special  (special),
    .shifted  (shifted),
    .sign     (in_q.sign),
    .rm       (in_q.rm),
    .fmt      (in_q.fmt),
    .out_data (out_d)
  );

  //////////////////////////////////////////////////////////////////////
  // Stage 2, result
  //////////////////////////////////////////////////////////////////////
  fp_pipe_reg #(
    .payload_t (div_sqrt_pkg::norm_out_t)
  ) u_out_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_in  (in_q_valid),
    .d         (out_d),
    .valid_out (out_valid),
    .q         (out_data)
  );

  // Every accepted item comes out exactly two edges later
  a_latency : assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> ##2 out_valid)
    else $error("result strobe missing two cycles after input");

endmodule

// File: tests/norm_cases.svh
// Directed cases for the normalize-and-round testbench, one add_case per row.
// Columns: name, mant, exp, {sign,sqrt_op}, cls {inf_a inf_b zero_a zero_b nan_a nan_b snan},
//          rm code, fmt (1 = FP16), expected result, expected flags {nv dz of uf nx}

// Special operands
add_case("nan_quiet", 28'h8000000, 10'sd127, 2'b00, 7'h04, 3'd0, 1'b0, 32'h7fc00000, 5'b00000);
add_case("nan_snan", 28'h8000000, 10'sd127, 2'b00, 7'h03, 3'd0, 1'b0, 32'h7fc00000, 5'b10000);
add_case("inf_div_inf", 28'h8000000, 10'sd127, 2'b00, 7'h60, 3'd0, 1'b0, 32'h7fc00000, 5'b10000);
add_case("sqrt_neg_inf", 28'h8000000, 10'sd127, 2'b11, 7'h40, 3'd0, 1'b0, 32'h7fc00000, 5'b10000);
add_case("inf_a_neg", 28'h8000000, 10'sd127, 2'b10, 7'h40, 3'd0, 1'b0, 32'hff800000, 5'b00100);
add_case("fin_div_inf", 28'h8000000, 10'sd127, 2'b10, 7'h20, 3'd0, 1'b0, 32'h80000000, 5'b00000);
add_case("zero_div_0", 28'h8000000, 10'sd127, 2'b00, 7'h18, 3'd0, 1'b0, 32'h7fc00000, 5'b11000);
add_case("x_div_0_pos", 28'h8000000, 10'sd127, 2'b00, 7'h08, 3'd0, 1'b0, 32'h7f800000, 5'b01000);
add_case("x_div_0_neg", 28'h8000000, 10'sd127, 2'b10, 7'h08, 3'd0, 1'b0, 32'hff800000, 5'b01000);
add_case("sqrt_neg", 28'h8000000, 10'sd127, 2'b11, 7'h00, 3'd0, 1'b0, 32'h7fc00000, 5'b10000);
add_case("sqrt_one", 28'h8000000, 10'sd127, 2'b01, 7'h00, 3'd0, 1'b0, 32'h3f800000, 5'b00000);

// Leading 0.1 pattern moves up one place
add_case("norm_left", 28'h4000008, 10'sd128, 2'b00, 7'h00, 3'd0, 1'b0, 32'h3f800001, 5'b00000);

// Tail of exactly one half, odd LSB, all modes and both signs
add_case("rne_pos", 28'h8000018, 10'sd127, 2'b00, 7'h00, 3'd0, 1'b0, 32'h3f800002, 5'b00001);
add_case("rne_neg", 28'h8000018, 10'sd127, 2'b10, 7'h00, 3'd0, 1'b0, 32'hbf800002, 5'b00001);
add_case("rtz_pos", 28'h8000018, 10'sd127, 2'b00, 7'h00, 3'd1, 1'b0, 32'h3f800001, 5'b00001);
add_case("rtz_neg", 28'h8000018, 10'sd127, 2'b10, 7'h00, 3'd1, 1'b0, 32'hbf800001, 5'b00001);
add_case("rdn_pos", 28'h8000018, 10'sd127, 2'b00, 7'h00, 3'd2, 1'b0, 32'h3f800001, 5'b00001);
add_case("rdn_neg", 28'h8000018, 10'sd127, 2'b10, 7'h00, 3'd2, 1'b0, 32'hbf800002, 5'b00001);
add_case("rup_pos", 28'h8000018, 10'sd127, 2'b00, 7'h00, 3'd3, 1'b0, 32'h3f800002, 5'b00001);
add_case("rup_neg", 28'h8000018, 10'sd127, 2'b10, 7'h00, 3'd3, 1'b0, 32'hbf800001, 5'b00001);
add_case("rne_even", 28'h8000028, 10'sd127, 2'b00, 7'h00, 3'd0, 1'b0, 32'h3f800002, 5'b00001);

// FP16 boxed, overflow, subnormal and flush
add_case("fp16_exact", 28'haaa0000, 10'sd15, 2'b00, 7'h00, 3'd0, 1'b1, 32'hffff3d55, 5'b00000);
add_case("fp16_rne", 28'haab0000, 10'sd15, 2'b10, 7'h00, 3'd0, 1'b1, 32'hffffbd56, 5'b00001);
add_case("of_fp32", 28'h8000000, 10'sd300, 2'b10, 7'h00, 3'd0, 1'b0, 32'hff800000, 5'b00100);
add_case("of_fp16", 28'h8000000, 10'sd40, 2'b00, 7'h00, 3'd0, 1'b1, 32'hffff7c00, 5'b00100);
add_case("subnormal", 28'h8000000, -10'sd1, 2'b00, 7'h00, 3'd0, 1'b0, 32'h00200000, 5'b00010);
add_case("flush_zero", 28'h8000000, -10'sd30, 2'b10, 7'h00, 3'd0, 1'b0, 32'h80000000, 5'b00010);

// File: tests/norm_round_unit_tb.sv
// Testbench for the normalize-and-round unit. Applies the directed case
// table one item at a time with a latency check, then a back-to-back
// burst of random truncation cases. One line per test, then a summary.

`timescale 1ns/1ps

module norm_round_unit_tb;

  localparam int c_timeout = 20;   // Cycles allowed for a result
  localparam int c_burst   = 16;

  logic                    clk;
  logic                    arst_n;
  logic                    in_valid;
  div_sqrt_pkg::norm_in_t  in_data;
  logic                    out_valid;
  div_sqrt_pkg::norm_out_t out_data;

  // Directed table, filled by load_cases
  string                   case_name[$];
  div_sqrt_pkg::norm_in_t  case_in[$];
  logic [31:0]             case_res[$];
  div_sqrt_pkg::fflags_t   case_flags[$];

  int errors;
  int tests;
  int failed_tests;
  int seed;

  norm_round_unit dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  always #10 clk = ~clk;  // 20 ns period

  //////////////////////////////////////////////////////////////////////
  // Table building and compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic add_case(input string name,
                          input logic [div_sqrt_pkg::c_mant_in_w-1:0] mant,
                          input logic signed [div_sqrt_pkg::c_exp_in_w-1:0] exp_v,
                          input logic [1:0] sign_sqrt, input logic [6:0] cls,
                          input logic [2:0] rm, input logic fmt,
                          input logic [31:0] res, input logic [4:0] flags);
    div_sqrt_pkg::norm_in_t d;
    d         = '0;
    d.mant    = mant;
    d.exp     = exp_v;
    d.sign    = sign_sqrt[1];
    d.sqrt_op = sign_sqrt[0];
    d.cls     = div_sqrt_pkg::op_class_t'(cls);
    d.rm      = div_sqrt_pkg::rm_e'(rm);
    d.fmt     = div_sqrt_pkg::fmt_e'(fmt);
    case_name.push_back(name);
    case_in.push_back(d);
    case_res.push_back(res);
    case_flags.push_back(div_sqrt_pkg::fflags_t'(flags));
  endtask

  task automatic load_cases;
    `include "norm_cases.svh"
  endtask

  task automatic check_result(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("mismatch %s result expected %08h actual %08h", name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_flags(input string name, input div_sqrt_pkg::fflags_t exp_v,
                             input div_sqrt_pkg::fflags_t act_v);
    if (act_v !== exp_v)
    begin
      $display("mismatch %s flags expected %05b actual %05b", name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    if (errors == err0)
      $display("PASS %s", name);
    else
    begin
      $display("FAIL %s", name);
      failed_tests++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reset, single items, burst
  //////////////////////////////////////////////////////////////////////
  task automatic reset_idle;
    int err0;
    err0 = errors;
    for (int k = 0; k < 8 + 3; k++)
    begin
      @(posedge clk);
      #1;
      if (out_valid !== 1'b0)
      begin
        $display("out_valid is not low during or right after reset (cycle %0d)", k);
        errors++;
      end
      if (k == 7)
        #1 arst_n = 1'b1;  // Released after the eighth edge
    end
    finish_test("reset_idle", err0);
  endtask

  task automatic run_case(input int idx);
    int   cyc;
    int   err0;
    logic seen;
    err0 = errors;
    @(posedge clk);
    #2;
    in_data  = case_in[idx];
    in_valid = 1'b1;
    @(posedge clk);           // Capture edge
    #2;
    in_valid = 1'b0;
    cyc      = 0;
    seen     = 1'b0;
    while (!seen && cyc < c_timeout)
    begin
      @(posedge clk);
      #1;
      cyc++;
      seen = out_valid;
    end
    if (!seen)
    begin
      $display("%s got no out_valid within %0d cycles", case_name[idx], c_timeout);
      errors++;
    end
    else
    begin
      // Seen after edge k means edge k+1 samples it
      if (cyc + 1 != 2)
      begin
        $display("%s result arrived %0d cycles after input, not 2", case_name[idx], cyc + 1);
        errors++;
      end
      check_result(case_name[idx], case_res[idx], out_data.result);
      check_flags(case_name[idx], case_flags[idx], out_data.flags);
      @(posedge clk);
      #1;
      if (out_valid)
      begin
        $display("%s produced a second out_valid", case_name[idx]);
        errors++;
      end
    end
    finish_test(case_name[idx], err0);
  endtask

  // Random rtz normals, one per cycle; result is the truncated packing
  task automatic run_burst;
    div_sqrt_pkg::norm_in_t items[c_burst];
    logic [31:0]            exp_res[c_burst];
    div_sqrt_pkg::fflags_t  exp_flg[c_burst];
    logic [31:0]            r;
    int                     e;
    int                     err0;
    err0 = errors;
    for (int k = 0; k < c_burst; k++)
    begin
      items[k]    = '0;
      r           = $random(seed);
      items[k].mant = {1'b1, r[26:0]};
      r           = $random(seed);
      e           = 1 + int'(r[15:0]) % 254;        // Normal range only
      items[k].exp  = 10'(e);
      items[k].sign = r[16];
      items[k].rm   = div_sqrt_pkg::rm_rtz;
      items[k].fmt  = div_sqrt_pkg::fmt_fp32;
      exp_res[k]  = {items[k].sign, items[k].exp[7:0], items[k].mant[26:4]};
      exp_flg[k]  = '0;
      exp_flg[k].nx = |items[k].mant[3:0];
    end
    for (int k = 0; k < c_burst + 3; k++)
    begin
      @(posedge clk);
      #1;
      // Item k-2 is due now
      if (k >= 2 && k - 2 < c_burst)
      begin
        if (out_valid !== 1'b1)
        begin
          $display("burst item %0d has no out_valid at its cycle", k - 2);
          errors++;
        end
        else
        begin
          check_result($sformatf("burst_%0d", k - 2), exp_res[k-2], out_data.result);
          check_flags($sformatf("burst_%0d", k - 2), exp_flg[k-2], out_data.flags);
        end
      end
      else if (out_valid !== 1'b0)
      begin
        $display("burst has an unexpected out_valid at cycle %0d", k);
        errors++;
      end
      #1;
      in_valid = (k < c_burst);
      if (k < c_burst)
        in_data = items[k];
    end
    finish_test("burst_rtz", err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    seed         = 7;
    load_cases();
    reset_idle();
    for (int idx = 0; idx < case_name.size(); idx++)
      run_case(idx);
    run_burst();
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: norm_round_unit.f
+incdir+tests
logic/div_sqrt_pkg.sv
logic/fp_pipe_reg.sv
logic/norm_special.sv
logic/norm_shift.sv
logic/norm_round.sv
logic/norm_round_unit.sv
tests/norm_round_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= norm_round_unit_tb
FLIST     ?= norm_round_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= run.log

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# The simulation passes only if the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
